// ==== Makefile ====
VERILATOR = verilator
VFLAGS = --binary --timing -Wno-fatal
TOP = msdft_tb
FILELIST = all.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

// ==== all.f ====
common/msdft_pkg.sv
common/cplx_if.sv
msdft/msdft_comb.sv
msdft/twiddle_table.sv
msdft/msdft_rotate.sv
msdft/msdft_integrate.sv
hdl/msdft_top.sv
sim/clk_gen.sv
sim/msdft_tb.sv

// ==== common/cplx_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// one complex sample plus its phase index, valid for a single cycle
interface cplx_if import msdft_pkg::*; #(
    parameter int W = 8
);

    logic valid;
    logic signed [W-1:0] re;
    logic signed [W-1:0] im;
    logic [PHASE_W-1:0] phase;

    modport src (
        output valid, re, im, phase
    );

    modport dst (
        input valid, re, im, phase
    );

endinterface

`default_nettype wire

// ==== common/msdft_pkg.sv ====
`default_nettype none

package msdft_pkg;

    // window length, one bin of a DFT_LEN point transform
    localparam int DFT_LEN = 16;
    localparam int PHASE_W = $clog2(DFT_LEN);
    localparam int FILL_W = PHASE_W + 1; // counts 0..DFT_LEN

    // input samples, Q1.7
    localparam int DIN_W = 8;
    localparam int DIN_POINT = 7;

    // comb difference grows by one bit
    localparam int COMB_W = DIN_W + 1;

    // twiddle factors, Q2.14
    localparam int TW_W = 16;
    localparam int TW_POINT = 14;

    // full complex product, exact
    localparam int MULT_W = COMB_W + TW_W + 1;
    localparam int MULT_POINT = DIN_POINT + TW_POINT;

    // sum of DFT_LEN products
    localparam int ACC_W = MULT_W + PHASE_W;

    // output format
    localparam int DOUT_W = 32;
    localparam int DOUT_POINT = 16;

    // fraction bits dropped by the rescale
    localparam int SHIFT = MULT_POINT - DOUT_POINT;

endpackage

`default_nettype wire

// ==== hdl/msdft_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module msdft_top import msdft_pkg::*; (
    input  wire logic clk,
    input  wire logic rst,

    input  wire logic signed [DIN_W-1:0] din_re,
    input  wire logic signed [DIN_W-1:0] din_im,
    input  wire logic din_valid,

    // twiddle table write port
    input  wire logic table_we,
    input  wire logic [PHASE_W-1:0] table_addr,
    input  wire logic [TW_W-1:0] table_re,
    input  wire logic [TW_W-1:0] table_im,

    output logic signed [DOUT_W-1:0] dout_re,
    output logic signed [DOUT_W-1:0] dout_im,
    output logic dout_valid
);

    cplx_if #(.W(COMB_W)) comb_if ();
    cplx_if #(.W(MULT_W)) prod_if ();

    msdft_comb comb0 (
        .clk       (clk),
        .rst       (rst),
        .din_re    (din_re),
        .din_im    (din_im),
        .din_valid (din_valid),
        .comb      (comb_if.src)
    );

    msdft_rotate rotate0 (
        .clk        (clk),
        .rst        (rst),
        .comb       (comb_if.dst),
        .prod       (prod_if.src),
        .table_we   (table_we),
        .table_addr (table_addr),
        .table_re   (table_re),
        .table_im   (table_im)
    );

    msdft_integrate integ0 (
        .clk        (clk),
        .rst        (rst),
        .prod       (prod_if.dst),
        .dout_re    (dout_re),
        .dout_im    (dout_im),
        .dout_valid (dout_valid)
    );

endmodule

`default_nettype wire

// ==== msdft/msdft_comb.sv ====
`timescale 1ns/10ps
`default_nettype none

module msdft_comb import msdft_pkg::*; (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic signed [DIN_W-1:0] din_re,
    input  wire logic signed [DIN_W-1:0] din_im,
    input  wire logic din_valid,
    cplx_if.src comb
);

    // window of past samples, addressed by the phase
    logic signed [DIN_W-1:0] mem_re [DFT_LEN];
    logic signed [DIN_W-1:0] mem_im [DFT_LEN];

    logic [PHASE_W-1:0] phase;
    logic [FILL_W-1:0] fill_cnt;
    logic filled;
    logic signed [DIN_W-1:0] old_re;
    logic signed [DIN_W-1:0] old_im;

    assign filled = (fill_cnt == FILL_W'(DFT_LEN));

    // sample from DFT_LEN strobes back, zero while the window is still filling
    assign old_re = filled ? mem_re[phase] : '0;
    assign old_im = filled ? mem_im[phase] : '0;

    always_ff @(posedge clk) begin
        if (din_valid) begin
            mem_re[phase] <= din_re; // old entry already read above
            mem_im[phase] <= din_im;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= '0;
            fill_cnt <= '0;
        end else if (din_valid) begin
            phase <= phase + 1'b1; // DFT_LEN is a power of two, wraps by itself
            if (!filled)
                fill_cnt <= fill_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            comb.valid <= 1'b0;
        else
            comb.valid <= din_valid;
    end

    always_ff @(posedge clk) begin
        if (din_valid) begin
            comb.re <= din_re - old_re;
            comb.im <= din_im - old_im;
            comb.phase <= phase;
        end
    end

endmodule

`default_nettype wire

// ==== msdft/msdft_integrate.sv ====
`timescale 1ns/10ps
`default_nettype none

module msdft_integrate import msdft_pkg::*; (
    input  wire logic clk,
    input  wire logic rst,
    cplx_if.dst prod,
    output logic signed [DOUT_W-1:0] dout_re,
    output logic signed [DOUT_W-1:0] dout_im,
    output logic dout_valid
);

    logic signed [ACC_W-1:0] acc_re;
    logic signed [ACC_W-1:0] acc_im;
    logic acc_valid;

    // running window sum, the comb already removed the oldest term
    always_ff @(posedge clk) begin
        if (rst) begin
            acc_re <= '0;
            acc_im <= '0;
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= prod.valid;
            if (prod.valid) begin
                acc_re <= acc_re + prod.re;
                acc_im <= acc_im + prod.im;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            dout_valid <= 1'b0;
        else
            dout_valid <= acc_valid;
    end

    // arithmetic shift floors toward minus infinity, result always fits
    always_ff @(posedge clk) begin
        if (acc_valid) begin
            dout_re <= acc_re >>> SHIFT;
            dout_im <= acc_im >>> SHIFT;
        end
    end

endmodule

`default_nettype wire

// ==== msdft/msdft_rotate.sv ====
`timescale 1ns/10ps
`default_nettype none

module msdft_rotate import msdft_pkg::*; (
    input  wire logic clk,
    input  wire logic rst,
    cplx_if.dst comb,
    cplx_if.src prod,
    input  wire logic table_we,
    input  wire logic [PHASE_W-1:0] table_addr,
    input  wire logic [TW_W-1:0] table_re,
    input  wire logic [TW_W-1:0] table_im
);

    logic signed [TW_W-1:0] tw_re;
    logic signed [TW_W-1:0] tw_im;

    // comb values waiting for the twiddle read
    logic signed [COMB_W-1:0] c_re;
    logic signed [COMB_W-1:0] c_im;
    logic [PHASE_W-1:0] c_phase;
    logic c_valid;

    twiddle_table table0 (
        .clk   (clk),
        .we    (table_we),
        .waddr (table_addr),
        .wre   (table_re),
        .wim   (table_im),
        .raddr (comb.phase),
        .rre   (tw_re),
        .rim   (tw_im)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            c_valid <= 1'b0;
            prod.valid <= 1'b0;
        end else begin
            c_valid <= comb.valid;
            prod.valid <= c_valid;
        end
    end

    always_ff @(posedge clk) begin
        c_re <= comb.re;
        c_im <= comb.im;
        c_phase <= comb.phase;
    end

    // (a+jb)(c+jd), operands widen to MULT_W so the result is exact
    always_ff @(posedge clk) begin
        if (c_valid) begin
            prod.re <= c_re * tw_re - c_im * tw_im;
            prod.im <= c_re * tw_im + c_im * tw_re;
            prod.phase <= c_phase;
        end
    end

endmodule

`default_nettype wire

// ==== msdft/twiddle_table.sv ====
`timescale 1ns/10ps
`default_nettype none

module twiddle_table import msdft_pkg::*; (
    input  wire logic clk,
    input  wire logic we,
    input  wire logic [PHASE_W-1:0] waddr,
    input  wire logic [TW_W-1:0] wre,
    input  wire logic [TW_W-1:0] wim,
    input  wire logic [PHASE_W-1:0] raddr,
    output logic signed [TW_W-1:0] rre,
    output logic signed [TW_W-1:0] rim
);

    logic [TW_W-1:0] mem_re [DFT_LEN];
    logic [TW_W-1:0] mem_im [DFT_LEN];

    always_ff @(posedge clk) begin
        if (we) begin
            mem_re[waddr] <= wre;
            mem_im[waddr] <= wim;
        end
    end

    // registered read, this is the first rotate cycle
    always_ff @(posedge clk) begin
        rre <= mem_re[raddr];
        rim <= mem_im[raddr];
    end

endmodule

`default_nettype wire

// ==== sim/clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

// 10 ns clock, reset held for the first 10 rising edges
module clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0; // released just after the edge, like the other inputs
    end

endmodule

`default_nettype wire

// ==== sim/msdft_stimulus.txt ====
# W addr tw_re tw_im | S gap re im exp_re exp_im | R | I cycles, all decimal
# expected = floor(sum over the window of x[n] * w[n mod 16] / 32)
I 4
# bin 1 twiddles, w[p] = exp(-j*2*pi*p/16) in Q2.14
W 0 16384 0
W 1 15137 -6270
W 2 11585 -11585
W 3 6270 -15137
W 4 0 -16384
W 5 -6270 -15137
W 6 -11585 -11585
W 7 -15137 -6270
W 8 -16384 0
W 9 -15137 6270
W 10 -11585 11585
W 11 -6270 15137
W 12 0 16384
W 13 6270 15137
W 14 11585 11585
W 15 15137 6270
# full scale tone at bin 1, back to back while the window fills
S 0 127 0 65024 0
S 0 117 49 129969 253
S 0 90 90 195135 253
S 0 49 117 260080 0
S 0 0 127 325104 0
S 0 -49 117 390050 253
S 0 -90 90 455216 253
S 0 -117 49 520161 0
S 0 -127 0 585185 0
S 0 -117 -49 650131 253
S 0 -90 -90 715296 253
S 0 -49 -117 780242 0
S 0 0 -127 845266 0
S 0 49 -117 910212 253
S 0 90 -90 975377 253
S 0 117 -49 1040323 0
# steady state, gaps are bits 7 to 5 of lcg 1664525*s+1013904223 seeded 32'ha1c2732f
S 6 127 0 1040323 0
S 1 117 49 1040323 0
S 2 90 90 1040323 0
S 6 49 117 1040323 0
S 0 0 127 1040323 0
S 3 -49 117 1040323 0
S 5 -90 90 1040323 0
S 5 -117 49 1040323 0
# reset in mid stream, the window starts over at phase 0
R
S 2 -37 100 -18944 51200
S 0 50 -20 788 31942
# bin 3 twiddles, w[p] = exp(-j*2*pi*3p/16)
W 0 16384 0
W 1 6270 -15137
W 2 -11585 -11585
W 3 -15137 6270
W 4 0 16384
W 5 15137 6270
W 6 11585 -11585
W 7 -6270 -15137
W 8 -16384 0
W 9 -6270 15137
W 10 11585 11585
W 11 15137 -6270
W 12 0 -16384
W 13 -15137 -6270
W 14 -11585 11585
W 15 6270 15137
R
# tone at bin 3 into a fresh window
S 0 127 0 65024 0
S 0 49 117 129969 -254
S 1 -90 90 195135 -254
S 0 -117 -49 260080 0
S 0 0 -127 325104 0
S 2 117 -49 390050 -254
S 0 90 90 455216 -254
S 0 -49 117 520161 0
I 8

// ==== sim/msdft_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module msdft_tb import msdft_pkg::*; ();

    localparam int LATENCY = 5;
    localparam int WAIT_LIMIT = 50;

    logic clk;
    logic por_rst;
    logic rst_pulse;
    logic rst;
    logic signed [DIN_W-1:0] din_re;
    logic signed [DIN_W-1:0] din_im;
    logic din_valid;
    logic table_we;
    logic [PHASE_W-1:0] table_addr;
    logic [TW_W-1:0] table_re;
    logic [TW_W-1:0] table_im;
    logic signed [DOUT_W-1:0] dout_re;
    logic signed [DOUT_W-1:0] dout_im;
    logic dout_valid;

    int cycle = 0;

    // samples in flight, oldest first
    int exp_re_q[$];
    int exp_im_q[$];
    int issue_q[$];
    int line_q[$];

    assign rst = por_rst | rst_pulse;

    clk_gen clk_gen0 (
        .clk (clk),
        .rst (por_rst)
    );

    msdft_top dut0 (
        .clk        (clk),
        .rst        (rst),
        .din_re     (din_re),
        .din_im     (din_im),
        .din_valid  (din_valid),
        .table_we   (table_we),
        .table_addr (table_addr),
        .table_re   (table_re),
        .table_im   (table_im),
        .dout_re    (dout_re),
        .dout_im    (dout_im),
        .dout_valid (dout_valid)
    );

    always @(posedge clk)
        cycle <= cycle + 1;

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        abort_run();
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            $display("Error: %s expected %0d, actual %0d", name, expected, actual);
            abort_run();
        end
    endtask

    // next cycle, strobes drop unless the caller raises them again
    task automatic step();
        @(posedge clk);
        #1;
        din_valid = 1'b0;
        table_we = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (issue_q.size() != 0) begin
            if (waited == WAIT_LIMIT) begin
                report_failure("an output never arrived within 50 cycles of its sample");
            end else begin
                step();
                waited++;
            end
        end
    endtask

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (por_rst !== 1'b0) begin
            if (waited == WAIT_LIMIT) begin
                report_failure("the power-on reset was never released");
            end else begin
                @(posedge clk);
                waited++;
            end
        end
        #1;
    endtask

    task automatic write_twiddle(input int addr, input int re, input int im);
        drain(); // no sample may be in flight during a table write
        step();
        table_we = 1'b1;
        table_addr = addr[PHASE_W-1:0];
        table_re = re[TW_W-1:0];
        table_im = im[TW_W-1:0];
    endtask

    task automatic send_sample(input int gap, input int re, input int im,
                               input int exp_re, input int exp_im, input int line_no);
        repeat (gap) step();
        step();
        din_valid = 1'b1;
        din_re = re[DIN_W-1:0];
        din_im = im[DIN_W-1:0];
        exp_re_q.push_back(exp_re);
        exp_im_q.push_back(exp_im);
        issue_q.push_back(cycle);
        line_q.push_back(line_no);
    endtask

    task automatic pulse_reset();
        drain();
        step();
        rst_pulse = 1'b1;
        step();
        rst_pulse = 1'b0;
    endtask

    task automatic check_output();
        int line_no;
        int issued;
        int exp_re;
        int exp_im;
        line_no = line_q.pop_front();
        issued = issue_q.pop_front();
        exp_re = exp_re_q.pop_front();
        exp_im = exp_im_q.pop_front();
        check_value($sformatf("line %0d latency", line_no), LATENCY, cycle - issued);
        check_value($sformatf("line %0d dout_re", line_no), exp_re, dout_re);
        check_value($sformatf("line %0d dout_im", line_no), exp_im, dout_im);
    endtask

    // outputs settle after the rising edge, so look at them on the falling one
    always @(negedge clk) begin
        if (dout_valid === 1'b1) begin
            if (issue_q.size() == 0)
                report_failure("dout_valid went high with no sample outstanding");
            else
                check_output();
        end
    end

    task automatic run_file(input int fd);
        string line;
        string op;
        int fld[5];
        int line_no;
        int code;
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            line_no++;
            if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                fld = '{default: 0};
                code = $sscanf(line, "%s %d %d %d %d %d", op,
                               fld[0], fld[1], fld[2], fld[3], fld[4]);
                case (op)
                    "W": write_twiddle(fld[0], fld[1], fld[2]);
                    "S": send_sample(fld[0], fld[1], fld[2], fld[3], fld[4], line_no);
                    "R": pulse_reset();
                    "I": repeat (fld[0]) step();
                    default: report_failure($sformatf("unknown opcode on line %0d", line_no));
                endcase
            end
        end
    endtask

    initial begin
        int fd;
        rst_pulse = 1'b0;
        din_valid = 1'b0;
        din_re = '0;
        din_im = '0;
        table_we = 1'b0;
        table_addr = '0;
        table_re = '0;
        table_im = '0;
        wait_reset_release();
        fd = $fopen("sim/msdft_stimulus.txt", "r");
        if (fd == 0) begin
            report_failure("could not open sim/msdft_stimulus.txt");
        end else begin
            run_file(fd);
            $fclose(fd);
            drain();
            $display("Everything OK");
            $finish;
        end
    end

endmodule

`default_nettype wire
